//--- include/gfx_defs.svh
// graphics defines: display timing, framebuffer size, shape geometry
// and the limits on drawing speed
`ifndef GFX_DEFS_SVH
`define GFX_DEFS_SVH

// display timing, small simulation-sized mode
`define H_ACTIVE    32  // active pixels per line
`define H_TOTAL     40  // total pixels per line
`define HS_START    34  // hsync goes low here
`define HS_END      37  // first cycle after hsync
`define V_ACTIVE    24  // active lines per frame
`define V_TOTAL     28  // total lines per frame
`define VS_START    25  // vsync goes low on this line
`define VS_END      26  // first line after vsync

// coordinates are signed
`define CORDW       8

// shape list
`define SHAPE_CNT   8   // number of nested circles
`define CX          16  // centre x
`define CY          12  // centre y
`define R_BASE      11  // radius of shape 0
`define R_STEP      1   // radius shrinks by this per shape

// drawing speed
`define FRAME_WAIT  2   // frames before drawing starts
`define PIX_FRAME   64  // pixel grants per frame

`endif

//--- logic/gfx_pkg.sv
// graphics package: FSM state types, colour index type and the
// 16-entry 12-bit palette
`default_nettype none

package gfx_pkg;

    // sequencer states
    typedef enum logic [2:0] {
        SEQ_IDLE,      // waiting for start frames
        SEQ_ISSUE,     // load command, raise req
        SEQ_WAIT_ACK,  // circle being drawn
        SEQ_RELEASE,   // req low, wait for ack low
        SEQ_DONE       // all shapes drawn
    } seq_state_t;

    // drawer states
    typedef enum logic [1:0] {
        FILL_IDLE,  // waiting for req
        FILL_LINE,  // settle half-width for this line
        FILL_SPAN,  // emit span pixels
        FILL_ACK    // ack high until req drops
    } fill_state_t;

    typedef logic [3:0] cidx_t;  // colour index

    // rgb 4:4:4, rainbow in 8..14
    localparam logic [11:0] palette [16] = '{
        12'h000, 12'h213, 12'h725, 12'h085,  // black, dark blue, purple, dark green
        12'hA53, 12'h554, 12'hCCC, 12'hFFE,  // brown, grey, light grey, white
        12'hF04, 12'hFA0, 12'hFE2, 12'h0E3,  // red, orange, yellow, green
        12'h2AF, 12'h87A, 12'hF7A, 12'hFCA   // blue, indigo, violet, peach
    };

endpackage

`default_nettype wire

//--- logic/display_timing.sv
// display timing: line and frame counters with registered sync,
// active and frame-start flags aligned to the screen position
`timescale 1ns/1ps
`default_nettype none
`include "gfx_defs.svh"

module display_timing (
    input  wire logic                     clk_100m,
    input  wire logic                     rst,
    output      logic signed [`CORDW-1:0] sx,     // screen x
    output      logic signed [`CORDW-1:0] sy,     // screen y
    output      logic                     hsync,  // active low
    output      logic                     vsync,  // active low
    output      logic                     de,     // inside active area
    output      logic                     frame   // one cycle at 0,0
);

    logic signed [`CORDW-1:0] nx, ny;  // position next cycle

    always_comb begin
        if (sx == `H_TOTAL - 1) begin  // end of line
            nx = '0;
            ny = (sy == `V_TOTAL - 1) ? '0 : sy + `CORDW'(1);
        end else begin
            nx = sx + `CORDW'(1);
            ny = sy;
        end
    end

    // flags decoded from next position so they line up with sx/sy
    always_ff @(posedge clk_100m) begin
        if (rst) begin
            sx    <= '0;
            sy    <= '0;
            hsync <= 1'b1;  // syncs idle high
            vsync <= 1'b1;
            de    <= 1'b1;  // 0,0 is active
            frame <= 1'b1;  // and starts a frame
        end else begin
            sx    <= nx;
            sy    <= ny;
            hsync <= !(nx >= `HS_START && nx < `HS_END);
            vsync <= !(ny >= `VS_START && ny < `VS_END);  // whole lines
            de    <= (nx < `H_ACTIVE) && (ny < `V_ACTIVE);
            frame <= (nx == 0) && (ny == 0);
        end
    end

    // counters stay inside the total timing
    sx_in_range: assert property (
        @(posedge clk_100m) disable iff (rst)
        sx < `H_TOTAL && sy < `V_TOTAL
    );

endmodule

`default_nettype wire

//--- logic/shape_sequencer.sv
// shape sequencer: decodes the circle list into commands over a
// four-phase req/ack handshake and meters pixel grants per frame
`timescale 1ns/1ps
`default_nettype none
`include "gfx_defs.svh"

module shape_sequencer (
    input  wire logic                     clk_100m,
    input  wire logic                     rst,
    input  wire logic                     frame,      // frame start pulse
    output      logic                     cmd_req,
    input  wire logic                     cmd_ack,
    output      logic signed [`CORDW-1:0] x0,         // centre x
    output      logic signed [`CORDW-1:0] y0,         // centre y
    output      logic signed [`CORDW-1:0] r0,         // radius
    output      gfx_pkg::cidx_t           cidx,       // fill colour
    output      logic                     pix_grant,  // drawer may emit
    output      logic                     draw_done   // sticky
);

    localparam int SIDW = $clog2(`SHAPE_CNT);
    localparam int FWW  = $clog2(`FRAME_WAIT + 1);
    localparam int PCW  = $clog2(`PIX_FRAME + 1);

    gfx_pkg::seq_state_t state;
    logic [SIDW-1:0]     shape_id;  // current shape
    logic [FWW-1:0]      wait_cnt;  // frames seen so far, saturating
    logic [PCW-1:0]      pix_cnt;   // grants this frame
    logic                wait_done;
    logic                last_shape;

    assign wait_done  = (wait_cnt == FWW'(`FRAME_WAIT));
    assign last_shape = (shape_id == SIDW'(`SHAPE_CNT - 1));

    // command fields, held while req is up
    always_ff @(posedge clk_100m) begin
        if (state == gfx_pkg::SEQ_ISSUE) begin
            x0   <= `CORDW'(`CX);
            y0   <= `CORDW'(`CY);
            r0   <= `CORDW'(`R_BASE - `R_STEP * int'(shape_id));
            cidx <= last_shape ? gfx_pkg::cidx_t'(0)    // inner disc black
                               : gfx_pkg::cidx_t'(8 + int'(shape_id));
        end
    end

    always_ff @(posedge clk_100m) begin
        if (rst) begin
            state     <= gfx_pkg::SEQ_IDLE;
            shape_id  <= '0;
            cmd_req   <= 1'b0;
            draw_done <= 1'b0;
        end else begin
            case (state)
                gfx_pkg::SEQ_IDLE: begin
                    if (wait_done && frame) state <= gfx_pkg::SEQ_ISSUE;  // next frame start
                end
                gfx_pkg::SEQ_ISSUE: begin
                    cmd_req <= 1'b1;  // fields load on same edge
                    state   <= gfx_pkg::SEQ_WAIT_ACK;
                end
                gfx_pkg::SEQ_WAIT_ACK: begin
                    if (cmd_ack) begin  // circle finished
                        cmd_req <= 1'b0;
                        state   <= gfx_pkg::SEQ_RELEASE;
                    end
                end
                gfx_pkg::SEQ_RELEASE: begin
                    if (!cmd_ack) begin  // handshake complete
                        if (last_shape) begin
                            draw_done <= 1'b1;
                            state     <= gfx_pkg::SEQ_DONE;
                        end else begin
                            shape_id <= shape_id + SIDW'(1);
                            state    <= gfx_pkg::SEQ_ISSUE;
                        end
                    end
                end
                gfx_pkg::SEQ_DONE: state <= gfx_pkg::SEQ_DONE;
                default: state <= gfx_pkg::SEQ_IDLE;
            endcase
        end
    end

    // speed control, budget only spent while a circle is in flight
    always_ff @(posedge clk_100m) begin
        if (rst) begin
            wait_cnt  <= '0;
            pix_cnt   <= '0;
            pix_grant <= 1'b0;
        end else begin
            pix_grant <= 1'b0;
            if (frame) begin
                if (!wait_done) wait_cnt <= wait_cnt + FWW'(1);
                pix_cnt <= '0;  // fresh budget
            end else if (wait_done && pix_cnt != PCW'(`PIX_FRAME)
                         && state == gfx_pkg::SEQ_WAIT_ACK) begin
                pix_grant <= 1'b1;
                pix_cnt   <= pix_cnt + PCW'(1);
            end
        end
    end

    // drawer sees one steady command per request
    cmd_stable: assert property (
        @(posedge clk_100m) disable iff (rst)
        cmd_req |=> !cmd_req || $stable({x0, y0, r0, cidx})
    );

    // no new request until the last ack has dropped
    req_after_ack: assert property (
        @(posedge clk_100m) disable iff (rst)
        !cmd_req && cmd_ack |=> !cmd_req
    );

endmodule

`default_nettype wire

//--- logic/circle_fill.sv
// filled circle drawer: walks the circle line by line from the top,
// settles the half-width per line, then emits one pixel per grant
`timescale 1ns/1ps
`default_nettype none
`include "gfx_defs.svh"

module circle_fill (
    input  wire logic                     clk_100m,
    input  wire logic                     rst,
    input  wire logic                     cmd_req,
    output      logic                     cmd_ack,   // circle complete
    input  wire logic signed [`CORDW-1:0] x0,
    input  wire logic signed [`CORDW-1:0] y0,
    input  wire logic signed [`CORDW-1:0] r0,
    input  wire gfx_pkg::cidx_t           cidx,
    input  wire logic                     pix_grant, // may emit this cycle
    output      logic                     pix_we,
    output      logic signed [`CORDW-1:0] pix_x,
    output      logic signed [`CORDW-1:0] pix_y,
    output      gfx_pkg::cidx_t           pix_cidx
);

    localparam int SQW = 2 * `CORDW + 1;  // room for sum of two squares

    gfx_pkg::fill_state_t     state;
    logic signed [`CORDW-1:0] xc, yc, rr;  // latched command
    gfx_pkg::cidx_t           col;
    logic signed [`CORDW-1:0] dy;          // line offset from centre
    logic signed [`CORDW-1:0] h;           // half-width of this line
    logic signed [`CORDW-1:0] px;          // current x in span

    logic signed [SQW-1:0] h_w, dy_w, r_w;  // sign-extended
    logic signed [SQW-1:0] h_sq, h1_sq, dy_sq, r_sq;
    logic                  too_wide, can_widen, span_end;

    assign h_w  = h;
    assign dy_w = dy;
    assign r_w  = rr;

    always_comb begin
        h_sq      = h_w * h_w;
        h1_sq     = (h_w + SQW'(1)) * (h_w + SQW'(1));
        dy_sq     = dy_w * dy_w;
        r_sq      = r_w * r_w;
        too_wide  = (h_sq + dy_sq) > r_sq;    // step in
        can_widen = (h1_sq + dy_sq) <= r_sq;  // step out
        span_end  = (px == xc + h);
    end

    // write port driven straight from the span walker
    assign pix_we   = (state == gfx_pkg::FILL_SPAN) && pix_grant;
    assign pix_x    = px;
    assign pix_y    = yc + dy;
    assign pix_cidx = col;

    always_ff @(posedge clk_100m) begin
        if (rst) begin
            state   <= gfx_pkg::FILL_IDLE;
            cmd_ack <= 1'b0;
        end else begin
            case (state)
                gfx_pkg::FILL_IDLE: begin
                    if (cmd_req && !cmd_ack) begin  // new command
                        xc    <= x0;
                        yc    <= y0;
                        rr    <= r0;
                        col   <= cidx;
                        dy    <= -r0;  // top line
                        h     <= '0;
                        state <= gfx_pkg::FILL_LINE;
                    end
                end
                gfx_pkg::FILL_LINE: begin
                    if (too_wide) begin
                        h <= h - `CORDW'(1);
                    end else if (can_widen) begin
                        h <= h + `CORDW'(1);
                    end else begin  // h settled
                        px    <= xc - h;
                        state <= gfx_pkg::FILL_SPAN;
                    end
                end
                gfx_pkg::FILL_SPAN: begin
                    if (pix_grant) begin  // else hold position
                        if (span_end) begin
                            if (dy == rr) begin  // bottom line done
                                cmd_ack <= 1'b1;
                                state   <= gfx_pkg::FILL_ACK;
                            end else begin
                                dy    <= dy + `CORDW'(1);
                                state <= gfx_pkg::FILL_LINE;
                            end
                        end else begin
                            px <= px + `CORDW'(1);
                        end
                    end
                end
                gfx_pkg::FILL_ACK: begin
                    if (!cmd_req) begin  // four-phase release
                        cmd_ack <= 1'b0;
                        state   <= gfx_pkg::FILL_IDLE;
                    end
                end
                default: state <= gfx_pkg::FILL_IDLE;
            endcase
        end
    end

    // sequencer budget is never exceeded
    we_needs_grant: assert property (
        @(posedge clk_100m) disable iff (rst)
        pix_we |-> pix_grant
    );

endmodule

`default_nettype wire

//--- logic/framebuffer.sv
// framebuffer: colour index array with a clipped draw write port and
// a scan-out read port with palette lookup, 2 cycles sx/sy to colour
`timescale 1ns/1ps
`default_nettype none
`include "gfx_defs.svh"

module framebuffer (
    input  wire logic                     clk_100m,
    input  wire logic                     rst,
    input  wire logic signed [`CORDW-1:0] sx,
    input  wire logic signed [`CORDW-1:0] sy,
    input  wire logic                     de,
    input  wire logic                     hsync,
    input  wire logic                     vsync,
    input  wire logic                     pix_we,
    input  wire logic signed [`CORDW-1:0] pix_x,
    input  wire logic signed [`CORDW-1:0] pix_y,
    input  wire gfx_pkg::cidx_t           pix_cidx,
    output      logic                     vga_hsync,
    output      logic                     vga_vsync,
    output      logic [3:0]               vga_r,
    output      logic [3:0]               vga_g,
    output      logic [3:0]               vga_b
);

    localparam int DEPTH = `H_ACTIVE * `V_ACTIVE;
    localparam int ADDRW = $clog2(DEPTH);

    gfx_pkg::cidx_t mem [DEPTH];  // one index per active pixel

    logic [ADDRW-1:0] wr_addr, rd_addr;
    logic             wr_in;      // write lands inside the array
    gfx_pkg::cidx_t   rd_cidx;    // stage 1 read data
    logic             de_p1, hsync_p1, vsync_p1;
    logic [11:0]      rgb;        // palette output

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;  // black at power-up
        end
    end

    // write side, clipped to the active area
    assign wr_in   = pix_x >= 0 && pix_x < `H_ACTIVE && pix_y >= 0 && pix_y < `V_ACTIVE;
    assign wr_addr = ADDRW'(pix_y) * ADDRW'(`H_ACTIVE) + ADDRW'(pix_x);

    always_ff @(posedge clk_100m) begin
        if (pix_we && wr_in) mem[wr_addr] <= pix_cidx;
    end

    // read side, address parked at 0 in blanking
    assign rd_addr = de ? ADDRW'(sy) * ADDRW'(`H_ACTIVE) + ADDRW'(sx) : '0;

    always_ff @(posedge clk_100m) begin
        rd_cidx <= mem[rd_addr];  // stage 1
    end

    always_ff @(posedge clk_100m) begin
        if (rst) begin
            de_p1    <= 1'b0;
            hsync_p1 <= 1'b1;
            vsync_p1 <= 1'b1;
        end else begin
            de_p1    <= de;  // match read latency
            hsync_p1 <= hsync;
            vsync_p1 <= vsync;
        end
    end

    assign rgb = gfx_pkg::palette[rd_cidx];

    // stage 2, registered video out
    always_ff @(posedge clk_100m) begin
        if (rst) begin
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
        end else begin
            vga_hsync <= hsync_p1;
            vga_vsync <= vsync_p1;
            vga_r     <= de_p1 ? rgb[11:8] : 4'h0;  // blank outside active
            vga_g     <= de_p1 ? rgb[7:4]  : 4'h0;
            vga_b     <= de_p1 ? rgb[3:0]  : 4'h0;
        end
    end

endmodule

`default_nettype wire

//--- logic/rainbow_top.sv
// rainbow top: eight nested filled circles drawn into the
// framebuffer and scanned out as VGA-style video
`timescale 1ns/1ps
`default_nettype none
`include "gfx_defs.svh"

module rainbow_top (
    input  wire logic       clk_100m,
    input  wire logic       rst,
    output      logic       vga_hsync,
    output      logic       vga_vsync,
    output      logic [3:0] vga_r,
    output      logic [3:0] vga_g,
    output      logic [3:0] vga_b,
    output      logic       draw_done
);

    logic signed [`CORDW-1:0] sx, sy;        // scan position
    logic                     hsync, vsync, de, frame;
    logic                     cmd_req, cmd_ack;
    logic signed [`CORDW-1:0] x0, y0, r0;    // circle command
    gfx_pkg::cidx_t           cidx;
    logic                     pix_grant, pix_we;
    logic signed [`CORDW-1:0] pix_x, pix_y;  // draw position
    gfx_pkg::cidx_t           pix_cidx;

    display_timing u_timing (
        .clk_100m, .rst,
        .sx, .sy, .hsync, .vsync, .de, .frame
    );

    shape_sequencer u_seq (
        .clk_100m, .rst, .frame,
        .cmd_req, .cmd_ack,
        .x0, .y0, .r0, .cidx,
        .pix_grant, .draw_done
    );

    circle_fill u_fill (
        .clk_100m, .rst,
        .cmd_req, .cmd_ack,
        .x0, .y0, .r0, .cidx,
        .pix_grant,
        .pix_we, .pix_x, .pix_y, .pix_cidx
    );

    framebuffer u_fb (
        .clk_100m, .rst,
        .sx, .sy, .de, .hsync, .vsync,
        .pix_we, .pix_x, .pix_y, .pix_cidx,
        .vga_hsync, .vga_vsync,
        .vga_r, .vga_g, .vga_b
    );

endmodule

`default_nettype wire

//--- verif/rainbow_tb.sv
// rainbow testbench: rebuilds the picture from the video pins and checks
// sync timing, blanking, start delay, drawing budget and the final image
`timescale 1ns/1ps
`default_nettype none
`include "gfx_defs.svh"

module rainbow_tb;

    localparam int FB_SIZE   = `H_ACTIVE * `V_ACTIVE;
    localparam int FRAME_CYC = `H_TOTAL * `V_TOTAL;

    logic       clk_100m;
    logic       rst;
    logic       vga_hsync, vga_vsync;
    logic [3:0] vga_r, vga_g, vga_b;
    logic       draw_done;

    gfx_pkg::cidx_t exp_cidx [FB_SIZE];  // model picture
    int   total_pix, line_steps;          // model pixel and line-settle counts
    int   min_frames;                     // earliest frame count for done
    int   limit_frames = 0;
    int   stable_ofs;                     // random frame after the final one
    int   errors = 0;
    int   checks = 0;
    logic run_over = 1'b0;

    int   cap_x, cap_y, cap_f;            // position now on the pins
    logic hs_d, vs_d;                     // syncs one sample back
    logic done_seen;
    int   done_f, stable_f;
    int   hs_cnt, vs_cnt, vs_low;         // sync period and width counters

    rainbow_top i_dut (
        .clk_100m, .rst,
        .vga_hsync, .vga_vsync,
        .vga_r, .vga_g, .vga_b,
        .draw_done
    );

    initial begin
        clk_100m = 1'b0;
        forever #5 clk_100m = ~clk_100m;  // 100 MHz
    end

    // expected colour index per pixel, straight from the fill rule
    task automatic build_model();
        int r, h, h_prev, col, y;
        for (int i = 0; i < FB_SIZE; i++) exp_cidx[i] = '0;
        total_pix  = 0;
        line_steps = 0;
        for (int k = 0; k < `SHAPE_CNT; k++) begin
            r      = `R_BASE - `R_STEP * k;
            col    = (k == `SHAPE_CNT - 1) ? 0 : 8 + k;  // inner disc black
            h_prev = 0;
            line_steps += 3;  // issue, latch and release per shape
            for (int dy = -r; dy <= r; dy++) begin
                h = 0;
                while ((h + 1) * (h + 1) + dy * dy <= r * r) h++;
                line_steps += ((h > h_prev) ? h - h_prev : h_prev - h) + 1;
                h_prev = h;
                y = `CY + dy;
                for (int x = `CX - h; x <= `CX + h; x++) begin
                    total_pix++;
                    if (x >= 0 && x < `H_ACTIVE && y >= 0 && y < `V_ACTIVE)
                        exp_cidx[y * `H_ACTIVE + x] = gfx_pkg::cidx_t'(col);  // later wins
                end
            end
        end
    endtask

    task automatic check_rgb(input string name, input int x, input int y,
                             input logic [11:0] want, input logic [11:0] got);
        checks++;
        assert (got == want) else begin
            errors++;
            $display("Error: %s at x=%0d y=%0d expected %03h actual %03h",
                     name, x, y, want, got);
        end
    endtask

    // picture capture, pins lag the scan position by two cycles
    always @(posedge clk_100m) begin : capture
        int x, y;
        logic [11:0] rgb;
        if (rst) begin
            cap_x     = `H_TOTAL - 2;  // first sample is two before 0,0
            cap_y     = `V_TOTAL - 1;
            cap_f     = -1;
            done_seen = 1'b0;
        end else begin
            x   = cap_x;
            y   = cap_y;
            rgb = {vga_r, vga_g, vga_b};
            if (hs_d && !vga_hsync) x = `HS_START;  // realign on sync edges
            if (vs_d && !vga_vsync) y = `VS_START;
            if (draw_done && !done_seen) begin
                done_seen = 1'b1;
                done_f    = cap_f;
                stable_f  = cap_f + 1 + stable_ofs;
                assert (cap_f + 1 >= min_frames) else begin
                    errors++;
                    $display("Error: budget frames started expected >= %0d actual %0d",
                             min_frames, cap_f + 1);
                end
            end
            if (cap_f < `FRAME_WAIT) begin
                assert (!draw_done) else begin
                    errors++;
                    $display("Error: draw_done high during start delay, frame %0d", cap_f);
                end
            end
            if (!(x < `H_ACTIVE && y < `V_ACTIVE))
                check_rgb("blanking", x, y, 12'h000, rgb);
            else if (cap_f >= 0 && cap_f < `FRAME_WAIT)
                check_rgb("start_delay", x, y, gfx_pkg::palette[0], rgb);
            else if (done_seen && cap_f == done_f + 1)
                check_rgb("final_image", x, y,
                          gfx_pkg::palette[exp_cidx[y * `H_ACTIVE + x]], rgb);
            else if (done_seen && cap_f == stable_f)
                check_rgb("stable_image", x, y,
                          gfx_pkg::palette[exp_cidx[y * `H_ACTIVE + x]], rgb);
            if (x == `H_TOTAL - 1) begin
                x = 0;
                if (y == `V_TOTAL - 1) begin
                    y = 0;
                    cap_f++;
                    if (done_seen && cap_f > stable_f) run_over = 1'b1;
                end else begin
                    y++;
                end
            end else begin
                x++;
            end
            cap_x = x;
            cap_y = y;
        end
    end

    // sync periods and vsync width by counting samples between edges
    always @(posedge clk_100m) begin : sync_check
        if (rst) begin
            hs_d   <= 1'b1;
            vs_d   <= 1'b1;
            hs_cnt <= 0;
            vs_cnt <= 0;
            vs_low <= 0;
        end else begin
            hs_d <= vga_hsync;
            vs_d <= vga_vsync;
            if (hs_d && !vga_hsync) begin  // hsync fell
                if (hs_cnt != 0) begin
                    assert (hs_cnt == `H_TOTAL) else begin
                        errors++;
                        $display("Error: hsync_period expected %0d actual %0d",
                                 `H_TOTAL, hs_cnt);
                    end
                end
                hs_cnt <= 1;
            end else if (hs_cnt != 0) begin
                hs_cnt <= hs_cnt + 1;
            end
            if (vs_d && !vga_vsync) begin  // vsync fell
                if (vs_cnt != 0) begin
                    assert (vs_cnt == FRAME_CYC) else begin
                        errors++;
                        $display("Error: vsync_period expected %0d actual %0d",
                                 FRAME_CYC, vs_cnt);
                    end
                end
                vs_cnt <= 1;
                vs_low <= 1;
            end else begin
                if (vs_cnt != 0) vs_cnt <= vs_cnt + 1;
                if (!vga_vsync) vs_low <= vs_low + 1;
                if (!vs_d && vga_vsync) begin  // vsync rose, one full line low
                    assert (vs_low == `H_TOTAL) else begin
                        errors++;
                        $display("Error: vsync_width expected %0d actual %0d",
                                 `H_TOTAL, vs_low);
                    end
                end
            end
        end
    end

    sync_idle_after_reset: assert property (
        @(posedge clk_100m) $fell(rst) |-> vga_hsync && vga_vsync
    ) else begin
        errors++;
        $display("Error: sync outputs not idle high right after reset");
    end

    hsync_width: assert property (
        @(posedge clk_100m) disable iff (rst)
        $fell(vga_hsync) |=> !vga_hsync ##1 !vga_hsync ##1 vga_hsync
    ) else begin
        errors++;
        $display("Error: hsync pulse is not exactly 3 cycles low");
    end

    done_sticky: assert property (
        @(posedge clk_100m) disable iff (rst)
        draw_done |=> draw_done
    ) else begin
        errors++;
        $display("Error: draw_done dropped after it was set");
    end

    initial begin : main
        rst = 1'b1;
        void'($urandom(83));
        stable_ofs = $urandom_range(3, 1);  // which later frame to recheck
        build_model();
        min_frames   = `FRAME_WAIT + (total_pix + `PIX_FRAME - 1) / `PIX_FRAME;
        limit_frames = `FRAME_WAIT + (total_pix + line_steps + `PIX_FRAME - 1) / `PIX_FRAME + 6;
        repeat (10) @(posedge clk_100m);
        #1 rst = 1'b0;
        wait (run_over);
        $display("%0d pixel checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        wait (limit_frames > 0);
        repeat (limit_frames * FRAME_CYC) @(posedge clk_100m);
        $display("Watchdog expired after %0d frames without finishing, %0d errors",
                 limit_frames, errors);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+include
logic/gfx_pkg.sv
logic/display_timing.sv
logic/shape_sequencer.sv
logic/circle_fill.sv
logic/framebuffer.sv
logic/rainbow_top.sv
verif/rainbow_tb.sv

//--- Makefile
SIM := obj_dir/Vrainbow_tb

.PHONY: all run clean

all: run

$(SIM): sources.f $(wildcard include/*.svh logic/*.sv verif/*.sv)
	verilator --binary --assert -j 0 --top-module rainbow_tb -f sources.f -o Vrainbow_tb

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
